// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - logic/core_pkg.sv
  - logic/insn_decoder.sv
  - logic/reg_banks.sv
  - logic/operand_fetch.sv
  - logic/execute_stage.sv
  - logic/hazard_fsm.sv
  - logic/stall_timer.sv
  - logic/exec_core.sv
  - target: test
    files:
      - bench/exec_core_props.sv
      - bench/exec_core_tb.sv

// ==== bench/exec_core_props.sv ====
`timescale 1ns/1ps

module exec_core_props (
	input  logic             CLK,
	input  logic             rst,
	input  logic             in_valid,
	input  core_pkg::word_t  in_insn,
	input  logic             in_ready,
	input  logic             res_valid
);

	int unsigned fails = 0;
	logic        wrote;
	logic        stalled;
	logic        xfer;
	logic        writes;

	assign stalled = in_valid && !in_ready;
	assign xfer    = in_valid && in_ready;

	// Codes 1 to 10 write unless the destination is register 0.
	assign writes = (in_insn[core_pkg::OPC_HI:core_pkg::OPC_LO] != 4'd0)
		&& (in_insn[core_pkg::OPC_HI:core_pkg::OPC_LO] <= 4'd10)
		&& (in_insn[core_pkg::RD_HI:core_pkg::RD_LO] != 5'd0);

	// Set once a writing instruction has gone in.
	always_ff @(posedge CLK) begin
		if (rst) begin
			wrote <= 1'b0;
		end else if (xfer && writes) begin
			wrote <= 1'b1;
		end
	end

	// ============================================================
	// Reset and result timing
	// ============================================================
	ready_after_reset: assert property (@(posedge CLK) $fell(rst) |-> in_ready && !res_valid)
		else begin $error("in_ready low or res_valid high right after reset"); fails++; end

	quiet_before_write: assert property (@(posedge CLK) disable iff (rst) !wrote |-> !res_valid)
		else begin $error("res_valid before any writing instruction"); fails++; end

	result_latency: assert property (@(posedge CLK) disable iff (rst)
		xfer && writes |-> ##2 res_valid)
		else begin $error("result missing two cycles after transfer"); fails++; end

	no_stray_result: assert property (@(posedge CLK) disable iff (rst)
		res_valid |-> $past(xfer && writes, 2))
		else begin $error("res_valid without a writing transfer two cycles back"); fails++; end

	// ============================================================
	// Handshake
	// ============================================================
	stall_bound: assert property (@(posedge CLK) disable iff (rst)
		!(stalled && $past(stalled) && $past(stalled, 2)))
		else begin $error("in_ready held low for more than two cycles"); fails++; end

	insn_stable: assert property (@(posedge CLK) disable iff (rst)
		stalled |=> in_valid && $stable(in_insn))
		else begin $error("in_insn changed or in_valid dropped while stalled"); fails++; end

endmodule

bind exec_core exec_core_props props0 (
	.CLK(CLK), .rst(rst), .in_valid(in_valid), .in_insn(in_insn), .in_ready(in_ready),
	.res_valid(res_valid)
);

// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb;

	localparam int CLK_PERIOD = 20;
	localparam int N_INSN     = 400;

	logic               CLK;
	logic               rst;
	logic               in_valid;
	core_pkg::word_t    in_insn;
	logic               in_ready;
	logic               res_valid;
	logic               res_bank;
	core_pkg::reg_idx_t res_dest;
	core_pkg::word_t    res_data;

	logic [31:0]        lfsr = 32'h425e_a6a6;
	core_pkg::word_t    shadow [2][32]; // Copy of both banks.
	core_pkg::result_t  expected [$];
	int                 errors = 0;
	int                 results_seen = 0;

	exec_core dut0 (
		.CLK(CLK), .rst(rst), .in_valid(in_valid), .in_insn(in_insn), .in_ready(in_ready),
		.res_valid(res_valid), .res_bank(res_bank), .res_dest(res_dest), .res_data(res_data)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// Fibonacci LFSR, taps 32 22 2 1.
	function automatic logic [31:0] draw(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Registers 0 to 7 only, to crowd the hazards.
	function automatic core_pkg::word_t random_insn();
		logic [3:0]  op;
		logic        bank;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [2:0]  rt;
		logic [11:0] imm;
		op   = 4'(draw(4));
		bank = 1'(draw(1));
		rd   = 3'(draw(3));
		rs   = 3'(draw(3));
		rt   = 3'(draw(3));
		imm  = 12'(draw(12));
		return {op, bank, 2'b00, rd, 2'b00, rs, 2'b00, rt, imm};
	endfunction

	// ============================================================
	// Reference model
	// ============================================================
	function automatic core_pkg::word_t alu_model(input logic [3:0] op, input core_pkg::word_t a,
			input core_pkg::word_t b, input logic [11:0] imm);
		case (op)
			core_pkg::OP_ADD:  return a + b;
			core_pkg::OP_SUB:  return a - b;
			core_pkg::OP_AND:  return a & b;
			core_pkg::OP_OR:   return a | b;
			core_pkg::OP_XOR:  return a ^ b;
			core_pkg::OP_SLL:  return a << imm[4:0];
			core_pkg::OP_SRL:  return a >> imm[4:0];
			core_pkg::OP_ADDI: return a + {{20{imm[11]}}, imm};
			core_pkg::OP_ORI:  return a | {20'd0, imm};
			core_pkg::OP_LUI:  return {20'd0, imm} << 20;
			default:           return '0;
		endcase
	endfunction

	task automatic model_insn(input core_pkg::word_t insn);
		logic [3:0]         op;
		logic               bank;
		core_pkg::reg_idx_t rd;
		core_pkg::result_t  r;
		op   = insn[31:28];
		bank = insn[27];
		rd   = insn[26:22];
		// Codes above LUI and dest 0 write nothing.
		if (op != 4'd0 && op <= 4'd10 && rd != '0) begin
			r.valid = 1'b1;
			r.bank  = bank;
			r.dest  = rd;
			r.data  = alu_model(op, shadow[bank][insn[21:17]], shadow[bank][insn[16:12]],
				insn[11:0]);
			shadow[bank][rd] = r.data;
			expected.push_back(r);
		end
	endtask

	task automatic compare_value(input string name, input core_pkg::word_t exp,
			input core_pkg::word_t act);
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Called on a falling edge; returns on the falling edge after the transfer.
	task automatic send_insn(input core_pkg::word_t insn);
		logic took;
		in_valid = 1'b1;
		in_insn  = insn;
		took     = 1'b0;
		while (!took) begin
			#1;
			took = in_ready; // Stable until the next rising edge.
			@(negedge CLK);
		end
		model_insn(insn);
		in_valid = 1'b0;
	endtask

	always @(negedge CLK) begin : result_monitor
		core_pkg::result_t e;
		if (!rst && res_valid) begin
			if (expected.size() == 0) begin
				errors++;
				$display("Result for register %0d arrived with no instruction pending", res_dest);
			end else begin
				e = expected.pop_front();
				results_seen++;
				compare_value($sformatf("result %0d bank", results_seen), e.bank, res_bank);
				compare_value($sformatf("result %0d dest", results_seen), e.dest, res_dest);
				compare_value($sformatf("result %0d data", results_seen), e.data, res_data);
			end
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	initial begin
		rst      = 1'b1;
		in_valid = 1'b0;
		in_insn  = '0;
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < 32; i++) begin
				shadow[b][i] = '0;
			end
		end
		repeat (2) @(negedge CLK);
		rst = 1'b0;

		for (int n = 0; n < N_INSN; n++) begin
			send_insn(random_insn());
			if (draw(2) == 32'd0) begin
				@(negedge CLK); // Idle gap.
			end
		end
		repeat (4) @(negedge CLK);

		if (expected.size() != 0) begin
			errors++;
			$display("%0d expected results never appeared", expected.size());
		end
		$display("Errors: %0d result checks, %0d assertions (%0d results compared)",
			errors, dut0.props0.fails, results_seen);
		if (errors == 0 && dut0.props0.fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Worst case is four cycles per instruction.
	initial begin
		#(CLK_PERIOD * (N_INSN * 4 + 40));
		$display("Watchdog expired before the instruction stream finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

	// ============================================================
	// Widths and instruction layout
	// ============================================================
	localparam int WORD_W   = 32;
	localparam int REG_W    = 5;
	localparam int NUM_REGS = 32;

	localparam int OPC_HI   = 31;
	localparam int OPC_LO   = 28;
	localparam int BANK_POS = 27;
	localparam int RD_HI    = 26;
	localparam int RD_LO    = 22;
	localparam int RS_HI    = 21;
	localparam int RS_LO    = 17;
	localparam int RT_HI    = 16;
	localparam int RT_LO    = 12;
	localparam int IMM_HI   = 11;
	localparam int IMM_LO   = 0;
	localparam int SA_HI    = 4; // Shift amount sits inside imm.
	localparam int SA_LO    = 0;
	localparam int IMM_W    = IMM_HI - IMM_LO + 1;

	localparam int STALL_MAX = 2; // Longest hazard stall.
	localparam int STALL_W   = $clog2(STALL_MAX + 1);

	typedef logic [WORD_W-1:0]      word_t;
	typedef logic [REG_W-1:0]       reg_idx_t;
	typedef logic [IMM_W-1:0]       imm_t;
	typedef logic [SA_HI-SA_LO:0]   sa_t;
	typedef logic [STALL_W-1:0]     stall_t;

	typedef enum logic [OPC_HI-OPC_LO:0] {
		OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_SLL, OP_SRL, OP_ADDI, OP_ORI, OP_LUI
	} opcode_t;

	// ============================================================
	// Pipeline structs
	// ============================================================
	typedef struct packed {
		opcode_t  op;
		logic     bank;
		logic     writes; // Low for NOP and for dest 0.
		reg_idx_t dest;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		imm_t     imm;
		sa_t      sa;
	} dec_t;

	typedef struct packed {
		logic  valid;
		ctrl_t ctrl;
		word_t op_a;
		word_t op_b;
		imm_t  imm;
		sa_t   sa;
	} of_stage_t;

	typedef struct packed {
		logic     valid;
		logic     bank;
		reg_idx_t dest;
		word_t    data;
	} result_t;

	typedef enum logic {HZ_RUN, HZ_WAIT} hazard_state_t;

endpackage

// ==== logic/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
	input  logic                CLK,
	input  logic                rst,
	input  logic                in_valid,
	input  core_pkg::word_t     in_insn,
	output logic                in_ready,
	output logic                res_valid,
	output logic                res_bank,
	output core_pkg::reg_idx_t  res_dest,
	output core_pkg::word_t     res_data
);

	core_pkg::dec_t       dec;
	core_pkg::word_t      data_a;
	core_pkg::word_t      data_b;
	logic                 rd_bank;
	core_pkg::reg_idx_t   src_a;
	core_pkg::reg_idx_t   src_b;
	core_pkg::of_stage_t  of_stage;
	core_pkg::result_t    result;
	core_pkg::ctrl_t      ex_ctrl;
	logic                 accept;
	logic                 timer_load;
	logic                 timer_done;
	core_pkg::stall_t     timer_value;

	// Opcode is not carried past execute.
	assign ex_ctrl = '{op: core_pkg::OP_NOP, bank: result.bank,
		writes: result.valid, dest: result.dest};

	assign res_valid = result.valid;
	assign res_bank  = result.bank;
	assign res_dest  = result.dest;
	assign res_data  = result.data;

	// ============================================================
	// Datapath
	// ============================================================
	insn_decoder dec0 (.insn(in_insn), .dec(dec));

	reg_banks banks0 (
		.CLK(CLK), .rst(rst), .rd_bank(rd_bank), .rd_a(src_a), .rd_b(src_b),
		.data_a(data_a), .data_b(data_b), .wr(result)
	);

	operand_fetch of0 (
		.CLK(CLK), .rst(rst), .accept(accept), .dec(dec), .data_a(data_a),
		.data_b(data_b), .bank(rd_bank), .src_a(src_a), .src_b(src_b),
		.of_stage(of_stage)
	);

	execute_stage ex0 (.CLK(CLK), .rst(rst), .of_stage(of_stage), .result(result));

	// ============================================================
	// Hazard control
	// ============================================================
	hazard_fsm hz0 (
		.CLK(CLK), .rst(rst), .in_valid(in_valid), .dec(dec),
		.of_ctrl(of_stage.ctrl), .of_valid(of_stage.valid),
		.ex_ctrl(ex_ctrl), .ex_valid(result.valid), .timer_done(timer_done),
		.in_ready(in_ready), .accept(accept), .timer_load(timer_load),
		.timer_value(timer_value)
	);

	stall_timer tmr0 (
		.CLK(CLK), .rst(rst), .load(timer_load), .value(timer_value), .done(timer_done)
	);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                 CLK,
	input  logic                 rst,
	input  core_pkg::of_stage_t  of_stage,
	output core_pkg::result_t    result
);

	localparam int EXT_W = core_pkg::WORD_W - core_pkg::IMM_W;

	core_pkg::word_t alu;
	core_pkg::word_t a;
	core_pkg::word_t b;

	assign a = of_stage.op_a;
	assign b = of_stage.op_b;

	always_comb begin
		case (of_stage.ctrl.op)
			core_pkg::OP_ADD:  alu = a + b;
			core_pkg::OP_SUB:  alu = a - b;
			core_pkg::OP_AND:  alu = a & b;
			core_pkg::OP_OR:   alu = a | b;
			core_pkg::OP_XOR:  alu = a ^ b;
			core_pkg::OP_SLL:  alu = a << of_stage.sa;
			core_pkg::OP_SRL:  alu = a >> of_stage.sa;
			core_pkg::OP_ADDI: alu = a + {{EXT_W{of_stage.imm[core_pkg::IMM_W-1]}}, of_stage.imm};
			core_pkg::OP_ORI:  alu = a | {{EXT_W{1'b0}}, of_stage.imm};
			core_pkg::OP_LUI:  alu = {of_stage.imm, {EXT_W{1'b0}}}; // imm << 20.
			default:           alu = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= of_stage.valid && of_stage.ctrl.writes;
		end
		result.bank <= of_stage.ctrl.bank;
		result.dest <= of_stage.ctrl.dest;
		result.data <= alu;
	end

endmodule

// ==== logic/hazard_fsm.sv ====
`timescale 1ns/1ps

module hazard_fsm (
	input  logic               CLK,
	input  logic               rst,
	input  logic               in_valid,
	input  core_pkg::dec_t     dec,
	input  core_pkg::ctrl_t    of_ctrl,
	input  logic               of_valid,
	input  core_pkg::ctrl_t    ex_ctrl,
	input  logic               ex_valid,
	input  logic               timer_done,
	output logic               in_ready,
	output logic               accept,
	output logic               timer_load,
	output core_pkg::stall_t   timer_value
);

	core_pkg::hazard_state_t state;
	core_pkg::hazard_state_t state_next;
	logic hit_of;
	logic hit_ex;
	logic hazard;

	// Source match against one in-flight writer.
	function automatic logic src_hit(input core_pkg::ctrl_t c, input logic v,
			input core_pkg::dec_t d);
		logic hit_rs;
		logic hit_rt;
		hit_rs = (d.rs != '0) && (d.rs == c.dest);
		hit_rt = (d.rt != '0) && (d.rt == c.dest);
		return v && c.writes && (c.bank == d.ctrl.bank) && (hit_rs || hit_rt);
	endfunction

	assign hit_of = src_hit(of_ctrl, of_valid, dec);
	assign hit_ex = src_hit(ex_ctrl, ex_valid, dec);
	assign hazard = in_valid && (hit_of || hit_ex);

	// Operand fetch match waits longest.
	assign timer_value = hit_of ? core_pkg::stall_t'(core_pkg::STALL_MAX) : core_pkg::stall_t'(1);
	assign timer_load  = (state == core_pkg::HZ_RUN) && hazard;
	assign in_ready    = (state == core_pkg::HZ_RUN) && !hazard;
	assign accept      = in_valid && in_ready;

	// ============================================================
	// State machine
	// ============================================================
	always_comb begin
		state_next = state;
		case (state)
			core_pkg::HZ_RUN:  if (hazard && !timer_done) state_next = core_pkg::HZ_WAIT;
			core_pkg::HZ_WAIT: if (timer_done) state_next = core_pkg::HZ_RUN;
			default:           state_next = core_pkg::HZ_RUN;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= core_pkg::HZ_RUN;
		end else begin
			state <= state_next;
		end
	end

endmodule

// ==== logic/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
	input  core_pkg::word_t insn,
	output core_pkg::dec_t  dec
);

	logic [core_pkg::OPC_HI-core_pkg::OPC_LO:0] raw_op;
	core_pkg::opcode_t op;

	// Opcode, with unused codes folded onto NOP.
	always_comb begin
		raw_op = insn[core_pkg::OPC_HI:core_pkg::OPC_LO];
		if (raw_op > core_pkg::OP_LUI) begin
			op = core_pkg::OP_NOP;
		end else begin
			op = core_pkg::opcode_t'(raw_op);
		end
	end

	always_comb begin
		dec.ctrl.op     = op;
		dec.ctrl.bank   = insn[core_pkg::BANK_POS];
		dec.ctrl.dest   = insn[core_pkg::RD_HI:core_pkg::RD_LO];
		dec.ctrl.writes = (op != core_pkg::OP_NOP) && (dec.ctrl.dest != '0);

		dec.rs  = insn[core_pkg::RS_HI:core_pkg::RS_LO];
		dec.rt  = insn[core_pkg::RT_HI:core_pkg::RT_LO];
		dec.imm = insn[core_pkg::IMM_HI:core_pkg::IMM_LO];
		dec.sa  = insn[core_pkg::SA_HI:core_pkg::SA_LO]; // Overlaps imm.
	end

endmodule

// ==== logic/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 accept,
	input  core_pkg::dec_t       dec,
	input  core_pkg::word_t      data_a,
	input  core_pkg::word_t      data_b,
	output logic                 bank,
	output core_pkg::reg_idx_t   src_a,
	output core_pkg::reg_idx_t   src_b,
	output core_pkg::of_stage_t  of_stage
);

	// Read addresses straight from the decoded fields.
	assign bank  = dec.ctrl.bank;
	assign src_a = dec.rs;
	assign src_b = dec.rt;

	// ============================================================
	// Stage register
	// ============================================================
	always_ff @(posedge CLK) begin
		if (rst) begin
			of_stage.valid <= 1'b0;
		end else begin
			of_stage.valid <= accept; // Bubble when nothing transfers.
		end
		of_stage.ctrl <= dec.ctrl;
		of_stage.op_a <= data_a;
		of_stage.op_b <= data_b;
		of_stage.imm  <= dec.imm;
		of_stage.sa   <= dec.sa;
	end

endmodule

// ==== logic/reg_banks.sv ====
`timescale 1ns/1ps

module reg_banks (
	input  logic                CLK,
	input  logic                rst,
	input  logic                rd_bank,
	input  core_pkg::reg_idx_t  rd_a,
	input  core_pkg::reg_idx_t  rd_b,
	output core_pkg::word_t     data_a,
	output core_pkg::word_t     data_b,
	input  core_pkg::result_t   wr
);

	// Bank 0 is the integer bank, bank 1 the second bank.
	core_pkg::word_t regs [2][core_pkg::NUM_REGS];

	// Register 0 of either bank reads as zero.
	assign data_a = (rd_a == '0) ? '0 : regs[rd_bank][rd_a];
	assign data_b = (rd_b == '0) ? '0 : regs[rd_bank][rd_b];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int b = 0; b < 2; b++) begin
				for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
					regs[b][i] <= '0;
				end
			end
		end else if (wr.valid && wr.dest != '0) begin
			regs[wr.bank][wr.dest] <= wr.data; // Only the named bank.
		end
	end

endmodule

// ==== logic/stall_timer.sv ====
`timescale 1ns/1ps

module stall_timer (
	input  logic              CLK,
	input  logic              rst,
	input  logic              load,
	input  core_pkg::stall_t  value,
	output logic              done
);

	// Cycles left after the current one.
	core_pkg::stall_t count;

	always_ff @(posedge CLK) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= value - core_pkg::stall_t'(1);
		end else if (count != '0) begin
			count <= count - core_pkg::stall_t'(1);
		end
	end

	// A one-cycle stall ends in the load cycle itself.
	assign done = load ? (value == core_pkg::stall_t'(1)) : (count == core_pkg::stall_t'(1));

endmodule

// ==== project.f ====
logic/core_pkg.sv
logic/insn_decoder.sv
logic/reg_banks.sv
logic/operand_fetch.sv
logic/execute_stage.sv
logic/hazard_fsm.sv
logic/stall_timer.sv
logic/exec_core.sv
bench/exec_core_props.sv
bench/exec_core_tb.sv
